// File: rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// Fetch front end constants
////////////////////////////////////////////////////////////

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

// Branch target buffer depth, indexed by PC word address
`define BTB_ENTRIES 64

// Opcode field
`define OPC_MSB 31
`define OPC_LSB 26

// Direct jump opcode
`define OPC_JUMP 6'd2

// 26-bit word target field of a direct jump
`define JUMP_FIELD_MSB 25
`define JUMP_FIELD_LSB 0

`endif

// File: rtl/fetchPkg.sv
package fetchPkg;

    ////////////////////////////////////////////////////////////
    // Shared fetch types
    ////////////////////////////////////////////////////////////

    // Two-bit saturating counter, 2 and 3 mean taken
    typedef logic [1:0] ctrT;

    // IF/ID payload, captured on every fetch hit
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        predTaken;
        logic [31:0] predTarget;
        // Cleared by a flush of the IF/ID register
        logic        notFlush;
        ctrT         ctr;
    } ifIdT;

    // ID/EX payload, seen at the decode outputs
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        predTaken;
        logic        isJump;
        // Address fetched right after this instruction
        logic [31:0] nextPc;
    } idExT;

endpackage

// File: rtl/branchPredictor.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branchPredictor
    import fetchPkg::*;
(
    input  logic        Clk,
    input  logic        rst,
    input  logic [31:0] lookupPc,
    input  logic        writeEnable,
    input  logic [31:0] updatePc,
    input  logic [31:0] updateTarget,
    input  logic [1:0]  cbUpdate,
    output logic        predTaken,
    output logic [31:0] predTarget,
    output ctrT         predCtr
);

    localparam int IdxW = $clog2(`BTB_ENTRIES);
    localparam int TagW = 30 - IdxW;

    logic [TagW-1:0]         tagMem    [`BTB_ENTRIES];
    logic [31:0]             targetMem [`BTB_ENTRIES];
    ctrT                     ctrMem    [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0] entryValid;

    logic [IdxW-1:0] lookupIdx;
    logic [IdxW-1:0] updateIdx;
    logic [TagW-1:0] lookupTag;
    logic [TagW-1:0] updateTag;
    logic            lookupHit;
    logic            updateHit;
    logic            updateTaken;
    ctrT             oldCtr;
    ctrT             newCtr;

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign lookupIdx = lookupPc[IdxW+1:2];
    assign lookupTag = lookupPc[31:IdxW+2];
    assign lookupHit = entryValid[lookupIdx] && (tagMem[lookupIdx] == lookupTag);

    // Misses read back as strongly not taken
    assign predCtr    = lookupHit ? ctrMem[lookupIdx] : 2'd0;
    assign predTaken  = lookupHit && predCtr[1];
    assign predTarget = targetMem[lookupIdx];

    ////////////////////////////////////////////////////////////
    // Update from execute
    ////////////////////////////////////////////////////////////

    assign updateIdx   = updatePc[IdxW+1:2];
    assign updateTag   = updatePc[31:IdxW+2];
    assign updateHit   = entryValid[updateIdx] && (tagMem[updateIdx] == updateTag);
    assign updateTaken = cbUpdate[1];
    assign oldCtr      = ctrMem[updateIdx];

    always_comb begin
        if (!updateHit) begin
            // Fresh entry starts weakly one way or the other
            newCtr = updateTaken ? 2'd2 : 2'd1;
        end else if (updateTaken) begin
            newCtr = (oldCtr == 2'd3) ? 2'd3 : oldCtr + 2'd1;
        end else begin
            newCtr = (oldCtr == 2'd0) ? 2'd0 : oldCtr - 2'd1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            entryValid <= '0;
            ctrMem     <= '{default: 2'd0};
        end else if (writeEnable) begin
            entryValid[updateIdx] <= 1'b1;
            ctrMem[updateIdx]     <= newCtr;
        end
    end

    always_ff @(posedge Clk) begin
        if (writeEnable) begin
            tagMem[updateIdx]    <= updateTag;
            targetMem[updateIdx] <= updateTarget;
        end
    end

    // Execute must stay quiet while the front end is in reset
    assert property (@(posedge Clk) rst |-> !writeEnable)
        else $error("BTB write during reset");

endmodule

// File: rtl/fetchLogic.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetchLogic
    import fetchPkg::*;
(
    input  logic        Clk,
    input  logic        rst,
    input  logic        flushPipeAndPc,
    input  logic [31:0] jmpAddr,
    input  logic        vicCtrl,
    input  logic [31:0] vicAddr,
    input  logic        idRedirect,
    input  logic [31:0] idTarget,
    input  logic        pcStall,
    input  logic        writeEnable,
    input  logic [31:0] jmpInstrAddr,
    input  logic [1:0]  cbUpdate,
    input  logic        icacheHit,
    input  logic [31:0] icacheData,
    output logic [31:0] icacheAddr,
    output logic        imiss,
    output ifIdT        ifIdIn
);

    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] seqPc;
    logic [31:0] redirectPc;
    logic        redirect;
    logic        btbTaken;
    logic [31:0] btbTarget;
    ctrT         btbCtr;

    branchPredictor btb (
        .Clk          (Clk),
        .rst          (rst),
        .lookupPc     (pc),
        .writeEnable  (writeEnable),
        .updatePc     (jmpInstrAddr),
        .updateTarget (jmpAddr),
        .cbUpdate     (cbUpdate),
        .predTaken    (btbTaken),
        .predTarget   (btbTarget),
        .predCtr      (btbCtr)
    );

    ////////////////////////////////////////////////////////////
    // Next PC selection
    ////////////////////////////////////////////////////////////

    assign redirect = flushPipeAndPc | vicCtrl | idRedirect;

    // Execute beats the VIC and the VIC beats decode
    always_comb begin
        if (flushPipeAndPc) begin
            redirectPc = jmpAddr;
        end else if (vicCtrl) begin
            redirectPc = vicAddr;
        end else begin
            redirectPc = idTarget;
        end
    end

    assign seqPc  = btbTaken ? btbTarget : pc + 32'd4;
    assign nextPc = redirect ? redirectPc : seqPc;

    // A miss or stall holds the PC but a redirect always lands
    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_PC;
        end else if (redirect || (icacheHit && !pcStall)) begin
            pc <= nextPc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Cache request and IF/ID payload
    ////////////////////////////////////////////////////////////

    assign icacheAddr = pc;
    assign imiss      = ~icacheHit;

    always_comb begin
        ifIdIn.valid      = icacheHit && !pcStall && !redirect;
        ifIdIn.instr      = icacheData;
        ifIdIn.pc         = pc;
        ifIdIn.predTaken  = btbTaken;
        ifIdIn.predTarget = btbTarget;
        ifIdIn.notFlush   = 1'b1;
        ifIdIn.ctr        = btbCtr;
    end

    // Redirect targets from execute and the VIC must be aligned too
    assert property (@(posedge Clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("Fetch PC not word aligned");

endmodule

// File: rtl/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    Clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    stall,
    input  payloadT in,
    output payloadT out
);

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////

    // Reset and flush win over a stall
    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            out <= '0;
        end else if (!stall) begin
            out <= in;
        end
    end

    // Downstream sees an empty bubble right after reset
    assert property (@(posedge Clk) rst |=> out == '0)
        else $error("Pipeline register not cleared by reset");

endmodule

// File: rtl/jumpDecode.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module jumpDecode
    import fetchPkg::*;
(
    input  ifIdT        ifId,
    input  logic [31:0] fetchPc,
    output logic        idRedirect,
    output logic [31:0] idTarget,
    output idExT        idExIn
);

    logic        entryValid;
    logic        isJump;
    logic        targetMiss;
    logic [5:0]  opcode;
    logic [25:0] wordTarget;

    ////////////////////////////////////////////////////////////
    // Direct jump detection
    ////////////////////////////////////////////////////////////

    // Flushed slots come through as all zero
    assign entryValid = ifId.valid && ifId.notFlush;
    assign opcode     = ifId.instr[`OPC_MSB:`OPC_LSB];
    assign wordTarget = ifId.instr[`JUMP_FIELD_MSB:`JUMP_FIELD_LSB];
    assign isJump     = entryValid && (opcode == `OPC_JUMP);

    // Region bits come from the jump's own PC
    assign idTarget = {ifId.pc[31:28], wordTarget, 2'b00};

    assign targetMiss = !ifId.predTaken || (ifId.predTarget != idTarget);
    assign idRedirect = isJump && targetMiss;

    ////////////////////////////////////////////////////////////
    // Decode payload
    ////////////////////////////////////////////////////////////

    always_comb begin
        idExIn.valid     = entryValid;
        idExIn.instr     = ifId.instr;
        idExIn.pc        = ifId.pc;
        idExIn.predTaken = ifId.predTaken;
        idExIn.isJump    = isJump;
        // fetchPc already follows this entry unless decode redirects
        idExIn.nextPc    = idRedirect ? idTarget : fetchPc;
    end

endmodule

// File: rtl/instrFetchStage.sv
`timescale 1ns/1ps

module instrFetchStage
    import fetchPkg::*;
(
    input  logic        Clk,
    input  logic        rst,
    // Instruction cache
    input  logic        icacheHit,
    input  logic [31:0] icacheData,
    output logic [31:0] icacheAddr,
    output logic        imiss,
    // Stall unit
    input  logic        pcStall,
    input  logic        ifIdStall,
    input  logic        ifIdFlush,
    // Execute
    input  logic        flushPipeAndPc,
    input  logic [31:0] jmpAddr,
    input  logic        writeEnable,
    input  logic [31:0] jmpInstrAddr,
    input  logic [1:0]  cbUpdate,
    // Interrupt controller
    input  logic        vicCtrl,
    input  logic [31:0] vicAddr,
    // Decode outputs
    output logic        idValid,
    output logic [31:0] idInstr,
    output logic [31:0] idPc,
    output logic        idPredTaken,
    output logic        idIsJump,
    output logic [31:0] idNextPc
);

    ifIdT        ifIdIn;
    ifIdT        ifIdOut;
    idExT        idExIn;
    idExT        idExOut;
    logic        idRedirect;
    logic [31:0] idTarget;
    logic        ifIdClear;
    logic        idExClear;

    fetchLogic fetch (
        .Clk            (Clk),
        .rst            (rst),
        .flushPipeAndPc (flushPipeAndPc),
        .jmpAddr        (jmpAddr),
        .vicCtrl        (vicCtrl),
        .vicAddr        (vicAddr),
        .idRedirect     (idRedirect),
        .idTarget       (idTarget),
        .pcStall        (pcStall),
        .writeEnable    (writeEnable),
        .jmpInstrAddr   (jmpInstrAddr),
        .cbUpdate       (cbUpdate),
        .icacheHit      (icacheHit),
        .icacheData     (icacheData),
        .icacheAddr     (icacheAddr),
        .imiss          (imiss),
        .ifIdIn         (ifIdIn)
    );

    ////////////////////////////////////////////////////////////
    // Stage registers and decode
    ////////////////////////////////////////////////////////////

    // A held jump must not be dropped while ID/EX is stalled
    assign ifIdClear = ifIdFlush | flushPipeAndPc | vicCtrl | (idRedirect & ~ifIdStall);
    // Late redirects also kill the entry moving into ID/EX
    assign idExClear = flushPipeAndPc | vicCtrl;

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .Clk   (Clk),
        .rst   (rst),
        .flush (ifIdClear),
        .stall (ifIdStall),
        .in    (ifIdIn),
        .out   (ifIdOut)
    );

    jumpDecode decode (
        .ifId       (ifIdOut),
        .fetchPc    (icacheAddr),
        .idRedirect (idRedirect),
        .idTarget   (idTarget),
        .idExIn     (idExIn)
    );

    pipeReg #(.payloadT(idExT)) idExReg (
        .Clk   (Clk),
        .rst   (rst),
        .flush (idExClear),
        .stall (ifIdStall),
        .in    (idExIn),
        .out   (idExOut)
    );

    assign idValid     = idExOut.valid;
    assign idInstr     = idExOut.instr;
    assign idPc        = idExOut.pc;
    assign idPredTaken = idExOut.predTaken;
    assign idIsJump    = idExOut.isJump;
    assign idNextPc    = idExOut.nextPc;

endmodule

// File: verification/fetchChecker.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetchChecker (
    input  logic        Clk,
    input  logic        rst,
    input  logic        icacheHit,
    input  logic [31:0] icacheAddr,
    input  logic        imiss,
    input  logic        pcStall,
    input  logic        ifIdStall,
    input  logic        flushPipeAndPc,
    input  logic [31:0] jmpAddr,
    input  logic        vicCtrl,
    input  logic [31:0] vicAddr,
    input  logic        writeEnable,
    input  logic [31:0] jmpInstrAddr,
    input  logic [1:0]  cbUpdate,
    input  logic        idValid,
    input  logic [31:0] idInstr,
    input  logic [31:0] idPc,
    input  logic        idPredTaken,
    input  logic        idIsJump,
    input  logic [31:0] idNextPc,
    output logic [31:0] errorCount,
    output logic [31:0] checkCount
);

    int          errors = 0;
    int          checks = 0;
    logic [31:0] memWords  [256];
    // Shadow BTB, tagged by the full word address
    logic [29:0] btbTag    [`BTB_ENTRIES];
    logic [31:0] btbTarget [`BTB_ENTRIES];
    logic [1:0]  btbCtr    [`BTB_ENTRIES];
    logic        btbValid  [`BTB_ENTRIES];
    // Expected PC and shadow contents of IF/ID and ID/EX
    logic [31:0] pcModel;
    logic        decValid;
    logic [31:0] decPc;
    logic        decPred;
    logic [31:0] decTarget;
    logic        outValid;
    logic [31:0] outPc;
    logic        outPred;
    logic [31:0] outTarget;

    assign errorCount = errors;
    assign checkCount = checks;

    function automatic logic isJumpWord(input logic [31:0] word);
        return word[`OPC_MSB:`OPC_LSB] == `OPC_JUMP;
    endfunction

    function automatic logic [31:0] jumpTarget(input logic [31:0] pc, input logic [31:0] word);
        return {pc[31:28], word[`JUMP_FIELD_MSB:0], 2'b00};
    endfunction

    function automatic int btbIndex(input logic [31:0] pc);
        return (pc >> 2) % `BTB_ENTRIES;
    endfunction

    task automatic storeWord(input int idx, input logic [31:0] word);
        memWords[idx] = word;
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic trainBtb(input logic [31:0] pc, input logic [31:0] target, input logic taken);
        int idx;
        idx = btbIndex(pc);
        if (btbValid[idx] && btbTag[idx] == pc[31:2]) begin
            if (taken && btbCtr[idx] != 2'd3) begin
                btbCtr[idx] = btbCtr[idx] + 2'd1;
            end else if (!taken && btbCtr[idx] != 2'd0) begin
                btbCtr[idx] = btbCtr[idx] - 2'd1;
            end
        end else begin
            btbCtr[idx] = taken ? 2'd2 : 2'd1;
        end
        btbValid[idx]  = 1'b1;
        btbTag[idx]    = pc[31:2];
        btbTarget[idx] = target;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare and advance the model once per cycle
    ////////////////////////////////////////////////////////////

    always @(negedge Clk) begin : observe
        logic [31:0] word;
        logic [31:0] decWord;
        logic [31:0] expNext;
        logic [31:0] idTgt;
        logic [31:0] predTgt;
        logic        predT;
        logic        idRedir;
        logic        fetchOk;
        int          idx;
        if (rst) begin
            pcModel  = `FETCH_RESET_PC;
            decValid = 1'b0;
            outValid = 1'b0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btbValid[i] = 1'b0;
                btbCtr[i]   = 2'd0;
            end
        end else begin
            compareValue("icacheAddr", icacheAddr, pcModel);
            compareValue("imiss", imiss, !icacheHit);
            compareValue("idValid", idValid, outValid);
            if (outValid) begin
                word = memWords[outPc[9:2]];
                compareValue("idPc", idPc, outPc);
                compareValue("idInstr", idInstr, word);
                compareValue("idIsJump", idIsJump, isJumpWord(word));
                compareValue("idPredTaken", idPredTaken, outPred);
                if (isJumpWord(word)) begin
                    expNext = jumpTarget(outPc, word);
                end else if (outPred) begin
                    expNext = outTarget;
                end else begin
                    expNext = outPc + 32'd4;
                end
                compareValue("idNextPc", idNextPc, expNext);
            end

            // Prediction seen by the current fetch
            idx     = btbIndex(pcModel);
            predT   = btbValid[idx] && btbTag[idx] == pcModel[31:2] && btbCtr[idx] >= 2'd2;
            predTgt = btbTarget[idx];

            // Decode redirect for a jump the prediction missed
            decWord = memWords[decPc[9:2]];
            idTgt   = jumpTarget(decPc, decWord);
            idRedir = decValid && isJumpWord(decWord) && (!decPred || decTarget != idTgt);
            fetchOk = icacheHit && !pcStall && !flushPipeAndPc && !vicCtrl && !idRedir;

            if (flushPipeAndPc || vicCtrl) begin
                decValid = 1'b0;
                outValid = 1'b0;
            end else if (!ifIdStall) begin
                outValid  = decValid;
                outPc     = decPc;
                outPred   = decPred;
                outTarget = decTarget;
                decValid  = fetchOk;
                decPc     = pcModel;
                decPred   = predT;
                decTarget = predTgt;
            end

            if (flushPipeAndPc) begin
                pcModel = jmpAddr;
            end else if (vicCtrl) begin
                pcModel = vicAddr;
            end else if (idRedir) begin
                pcModel = idTgt;
            end else if (icacheHit && !pcStall) begin
                pcModel = predT ? predTgt : pcModel + 32'd4;
            end

            if (writeEnable) begin
                trainBtb(jmpInstrAddr, jmpAddr, cbUpdate[1]);
            end
        end
    end

endmodule

// File: verification/fetchTb.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetchTb;

    localparam int StimCycles    = 4000;
    localparam int ResetCycles   = 16;
    localparam int TimeoutCycles = StimCycles + StimCycles / 10;

    logic        Clk;
    logic        rst;
    logic        icacheHit;
    logic [31:0] icacheData;
    logic [31:0] icacheAddr;
    logic        imiss;
    logic        pcStall;
    logic        ifIdStall;
    logic        ifIdFlush;
    logic        flushPipeAndPc;
    logic [31:0] jmpAddr;
    logic        writeEnable;
    logic [31:0] jmpInstrAddr;
    logic [1:0]  cbUpdate;
    logic        vicCtrl;
    logic [31:0] vicAddr;
    logic        idValid;
    logic [31:0] idInstr;
    logic [31:0] idPc;
    logic        idPredTaken;
    logic        idIsJump;
    logic [31:0] idNextPc;
    logic [31:0] errorCount;
    logic [31:0] checkCount;

    logic [31:0] icacheMem    [256];
    // One fixed target per branch slot so counters can build up
    logic [31:0] branchTarget [64];
    integer      seed;
    int          cycleCount = 0;

    instrFetchStage dut (.*);

    fetchChecker chk (.*);

    // Cache answers in the same cycle
    assign icacheData = icacheMem[icacheAddr[9:2]];

    initial Clk = 1'b0;
    always #4 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run hit the cycle limit before the stimulus finished");
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic fillCache();
        logic [31:0] word;
        logic [31:0] pick;
        for (int i = 0; i < 256; i++) begin
            word = $random(seed);
            pick = $random(seed);
            // Roughly one in eight becomes a jump into the first 1 KB
            if (pick[2:0] == 3'd0) begin
                word = {`OPC_JUMP, 18'd0, word[7:0]};
            end
            icacheMem[i] = word;
            chk.storeWord(i, word);
        end
        for (int i = 0; i < 64; i++) begin
            pick = $random(seed);
            branchTarget[i] = {22'd0, pick[7:0], 2'b00};
        end
    endtask

    task automatic quietInputs();
        icacheHit      = 1'b1;
        pcStall        = 1'b0;
        ifIdStall      = 1'b0;
        ifIdFlush      = 1'b0;
        flushPipeAndPc = 1'b0;
        vicCtrl        = 1'b0;
        writeEnable    = 1'b0;
        cbUpdate       = 2'b00;
    endtask

    task automatic driveRandomCycle();
        logic [31:0] r1;
        logic [31:0] r2;
        @(posedge Clk);
        #1;
        r1 = $random(seed);
        r2 = $random(seed);
        icacheHit      = r1[2:0] != 3'd0;
        pcStall        = r1[6:3] < 4'd2;
        ifIdStall      = pcStall;
        flushPipeAndPc = r1[11:7] == 5'd0;
        vicCtrl        = r1[16:12] == 5'd0;
        writeEnable    = r1[19:17] == 3'd0;
        cbUpdate       = {r1[20], r1[21]};
        jmpInstrAddr   = {24'd0, r2[5:0], 2'b00};
        vicAddr        = {22'd0, r2[23:16], 2'b00};
        // Updates reuse the recorded target of their slot
        if (writeEnable) begin
            jmpAddr = branchTarget[r2[5:0]];
        end else begin
            jmpAddr = {22'd0, r2[15:8], 2'b00};
        end
    endtask

    initial begin
        seed         = 32'h0601_343f;
        rst          = 1'b1;
        icacheHit    = 1'b0;
        pcStall      = 1'b0;
        ifIdStall    = 1'b0;
        ifIdFlush    = 1'b0;
        flushPipeAndPc = 1'b0;
        jmpAddr      = 32'd0;
        writeEnable  = 1'b0;
        jmpInstrAddr = 32'd0;
        cbUpdate     = 2'b00;
        vicCtrl      = 1'b0;
        vicAddr      = 32'd0;
        fillCache();
        repeat (ResetCycles) @(posedge Clk);
        #1;
        rst = 1'b0;
        repeat (StimCycles) driveRandomCycle();
        @(posedge Clk);
        #1;
        quietInputs();
        // Let the last entries drain through both stage registers
        repeat (6) @(posedge Clk);
        @(negedge Clk);
        #1;
        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/fetchPkg.sv
rtl/branchPredictor.sv
rtl/fetchLogic.sv
rtl/pipeReg.sv
rtl/jumpDecode.sv
rtl/instrFetchStage.sv
verification/fetchChecker.sv
verification/fetchTb.sv
